//--- files.f
+incdir+.
cpuPkg.sv
stageRegister.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
resultStage.sv
cpuTop.sv
cpuTb.sv

//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing -j 0 --top-module cpuTb -f files.f -o simv
	./obj_dir/simv

lint:
	verilator --lint-only --timing --top-module cpuTb -f files.f

clean:
	rm -rf obj_dir

//--- program.hex
// One RV32I instruction word per line, word address 0 first
00500093
FFD08113
002081B3
40310233
003272B3
0012E333
002343B3
00722433
123454B7
00148013
00900533
10102023
10202223
10302423
10402623
10502823
10602A23
10702C23
10802E23
12902023
12A02223
20002583
00158613
20402683
00C68733
20E02423
00100793
00F78463
2EF02E23
00000813
00500893
00180813
31002023
FF181CE3
00000063

//--- cpuTb.sv
`timescale 1ns/100ps

module cpuTb;

  localparam int AccessesPerRun = 18;
  localparam int WatchdogCycles = 200 * 2 * AccessesPerRun;
  localparam logic [31:0] SeedA = 32'h1357_9BDF;
  localparam logic [31:0] SeedB = 32'h0246_8ACE;

  logic           clk;
  logic           rstN;
  cpuPkg::wbReq_t wbOut;
  logic [31:0]    wbDatIn;
  logic           wbAck;

  // Slave model state
  logic [31:0]    mem [256];
  cpuPkg::wbReq_t accessLog [$];
  cpuPkg::wbReq_t held;
  logic           active;
  int             ackDelay;
  int             maxDelay;
  integer         seed;

  cpuTop dut (
    .clk     (clk),
    .rstN    (rstN),
    .wbOut   (wbOut),
    .wbDatIn (wbDatIn),
    .wbAck   (wbAck)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic reportMismatch(input string msg);
    abortRun($sformatf("FAIL at %0t: %s", $time, msg));
  endtask

  task automatic checkIdle(input cpuPkg::wbReq_t got);
    if (got.cyc !== 1'b0 || got.stb !== 1'b0) begin
      reportMismatch($sformatf("bus not idle, cyc=%b stb=%b", got.cyc, got.stb));
    end
  endtask

  task automatic checkRead(input cpuPkg::wbReq_t got, input cpuPkg::word_t adr);
    if (got.we !== 1'b0 || got.adr !== adr || got.sel !== 4'hF) begin
      reportMismatch($sformatf("read expected adr=%h, got we=%b adr=%h sel=%h",
                               adr, got.we, got.adr, got.sel));
    end
  endtask

  task automatic checkWrite(input cpuPkg::wbReq_t got, input cpuPkg::word_t adr,
                            input cpuPkg::word_t dat);
    if (got.we !== 1'b1 || got.adr !== adr || got.dat !== dat || got.sel !== 4'hF) begin
      reportMismatch($sformatf("write expected adr=%h dat=%h, got we=%b adr=%h dat=%h",
                               adr, dat, got.we, got.adr, got.dat));
    end
  endtask

  // Wishbone slave that acks after a random delay and logs each request once
  always @(negedge clk or negedge rstN) begin
    if (!rstN) begin
      wbAck  = 1'b0;
      active = 1'b0;
      // Requests seen during reset still land in the log
      if (wbOut.cyc && wbOut.stb) begin
        accessLog.push_back(wbOut);
      end
    end else if (wbAck) begin
      wbAck  = 1'b0;
      active = 1'b0;
    end else if (wbOut.cyc && wbOut.stb) begin
      if (!active) begin
        active   = 1'b1;
        held     = wbOut;
        ackDelay = $unsigned($random(seed)) % (maxDelay + 1);
        accessLog.push_back(wbOut);
      end else if (wbOut.adr !== held.adr || wbOut.dat !== held.dat ||
                   wbOut.we !== held.we) begin
        reportMismatch("request changed while waiting for ack");
      end
      if (ackDelay == 0) begin
        wbAck = 1'b1;
        if (wbOut.we) begin
          mem[wbOut.adr[9:2]] = wbOut.dat;
        end else begin
          wbDatIn = mem[wbOut.adr[9:2]];
        end
      end else begin
        ackDelay--;
      end
    end
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    abortRun("Timeout: the expected bus accesses did not all arrive in time");
  end

  task automatic nextAccess(output cpuPkg::wbReq_t req);
    while (accessLog.size() == 0) begin
      @(posedge clk);
    end
    req = accessLog.pop_front();
  endtask

  task automatic holdReset();
    @(negedge clk);
    rstN = 1'b0;
    repeat (10) begin
      @(negedge clk);
      checkIdle(wbOut);
      if (accessLog.size() != 0) begin
        abortRun("A bus access was logged while reset was asserted");
      end
    end
    rstN = 1'b1;
  endtask

  task automatic testResetIdle();
    holdReset();
    // First store is still several instructions away
    repeat (5) begin
      @(negedge clk);
      checkIdle(wbOut);
    end
  endtask

  task automatic testAluForwarding();
    cpuPkg::wbReq_t req;
    cpuPkg::word_t  x [1:10];
    x[1]  = 32'd5;
    x[2]  = x[1] + 32'hFFFF_FFFD;
    x[3]  = x[1] + x[2];
    x[4]  = x[2] - x[3];
    x[5]  = x[4] & x[3];
    x[6]  = x[5] | x[1];
    x[7]  = x[6] ^ x[2];
    x[8]  = ($signed(x[4]) < $signed(x[7])) ? 32'd1 : 32'd0;
    x[9]  = 32'h12345 << 12;
    // ADDI to x0 is discarded, so x10 = 0 + x9
    x[10] = 32'd0 + x[9];
    for (int i = 1; i <= 10; i++) begin
      nextAccess(req);
      checkWrite(req, 32'h100 + 32'(4 * (i - 1)), x[i]);
    end
  endtask

  task automatic testLoadUse();
    cpuPkg::wbReq_t req;
    nextAccess(req);
    checkRead(req, 32'h200);
    nextAccess(req);
    checkRead(req, 32'h204);
    nextAccess(req);
    checkWrite(req, 32'h208, (SeedA + 32'd1) + SeedB);
  endtask

  task automatic testBranches();
    cpuPkg::wbReq_t req;
    for (int k = 1; k <= 5; k++) begin
      nextAccess(req);
      checkWrite(req, 32'h300, 32'(k));
    end
    // Core now spins in its self-loop
    repeat (40) @(posedge clk);
    if (accessLog.size() != 0) begin
      abortRun("An unexpected bus access followed the branch loop");
    end
  endtask

  task automatic testBackPressure();
    maxDelay = 4;
    holdReset();
    testAluForwarding();
    testLoadUse();
    testBranches();
  endtask

  initial begin
    seed     = 251;
    maxDelay = 0;
    rstN     = 1'b0;
    wbAck    = 1'b0;
    wbDatIn  = '0;
    active   = 1'b0;
    ackDelay = 0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'hDEAD_0000 + 32'(i);
    end
    mem[32'h200 >> 2] = SeedA;
    mem[32'h204 >> 2] = SeedB;

    testResetIdle();
    testAluForwarding();
    testLoadUse();
    testBranches();
    testBackPressure();

    $display("=== PASS ===");
    $finish;
  end

endmodule

//--- cpuTop.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module cpuTop (
  input  logic             clk,
  input  logic             rstN,
  output cpuPkg::wbReq_t   wbOut,
  input  logic [`XLEN-1:0] wbDatIn,
  input  logic             wbAck
);

  cpuPkg::ifId_t     fetched;
  cpuPkg::ifId_t     ifIdQ;
  cpuPkg::idEx_t     decoded;
  cpuPkg::idEx_t     idExQ;
  cpuPkg::exMem_t    exResult;
  cpuPkg::exMem_t    exMemQ;
  cpuPkg::memWb_t    toWb;
  cpuPkg::memWb_t    memWbQ;
  cpuPkg::regWrite_t regWrite;
  cpuPkg::redirect_t redirect;
  logic              loadUseStall;
  logic              memStall;

  fetchStage fetch (
    .clk      (clk),
    .rstN     (rstN),
    .stall    (memStall | loadUseStall),
    .redirect (redirect),
    .fetched  (fetched)
  );

  stageRegister #(.payload_t(cpuPkg::ifId_t)) ifIdReg (
    .clk   (clk),
    .rstN  (rstN),
    .stall (memStall | loadUseStall),
    .flush (redirect.taken),
    .d     (fetched),
    .q     (ifIdQ)
  );

  decodeStage decode (
    .clk          (clk),
    .rstN         (rstN),
    .ifId         (ifIdQ),
    .regWrite     (regWrite),
    .exLoadRd     (idExQ.rd),
    .exIsLoad     (idExQ.memRead),
    .decoded      (decoded),
    .loadUseStall (loadUseStall)
  );

  // Load-use inserts a bubble here while IF/ID holds
  stageRegister #(.payload_t(cpuPkg::idEx_t)) idExReg (
    .clk   (clk),
    .rstN  (rstN),
    .stall (memStall),
    .flush (redirect.taken | loadUseStall),
    .d     (decoded),
    .q     (idExQ)
  );

  executeStage execute (
    .idEx     (idExQ),
    .exMemFwd (exMemQ),
    .wbFwd    (regWrite),
    .result   (exResult),
    .redirect (redirect)
  );

  stageRegister #(.payload_t(cpuPkg::exMem_t)) exMemReg (
    .clk   (clk),
    .rstN  (rstN),
    .stall (memStall),
    .flush (1'b0),
    .d     (exResult),
    .q     (exMemQ)
  );

  resultStage result (
    .clk      (clk),
    .rstN     (rstN),
    .exMem    (exMemQ),
    .memWb    (memWbQ),
    .wbOut    (wbOut),
    .wbDatIn  (wbDatIn),
    .wbAck    (wbAck),
    .memStall (memStall),
    .toWb     (toWb),
    .regWrite (regWrite)
  );

  stageRegister #(.payload_t(cpuPkg::memWb_t)) memWbReg (
    .clk   (clk),
    .rstN  (rstN),
    .stall (memStall),
    .flush (1'b0),
    .d     (toWb),
    .q     (memWbQ)
  );

endmodule

//--- resultStage.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module resultStage (
  input  logic                clk,
  input  logic                rstN,
  input  cpuPkg::exMem_t      exMem,
  input  cpuPkg::memWb_t      memWb,
  output cpuPkg::wbReq_t      wbOut,
  input  logic [`XLEN-1:0]    wbDatIn,
  input  logic                wbAck,
  output logic                memStall,
  output cpuPkg::memWb_t      toWb,
  output cpuPkg::regWrite_t   regWrite
);

  logic isMemOp;
  logic pending;
  logic done;

  assign isMemOp = exMem.memRead || exMem.memWrite;

  // Bus cycle in flight
  assign pending = wbOut.cyc;
  assign done    = pending && wbAck;

  // Request and payload stay put until the slave acks
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wbOut <= '0;
    end else if (done) begin
      wbOut.cyc <= 1'b0;
      wbOut.stb <= 1'b0;
      wbOut.we  <= 1'b0;
    end else if (isMemOp && !pending) begin
      wbOut.cyc <= 1'b1;
      wbOut.stb <= 1'b1;
      wbOut.we  <= exMem.memWrite;
      wbOut.sel <= '1;
      wbOut.adr <= exMem.aluResult;
      wbOut.dat <= exMem.storeData;
    end
  end

  // Low in the ack cycle so the access retires on that edge
  assign memStall = isMemOp && !done;

  always_comb begin
    toWb.value    = exMem.memRead ? wbDatIn : exMem.aluResult;
    toWb.rd       = exMem.rd;
    toWb.regWrite = exMem.regWrite;
  end

  always_comb begin
    regWrite.en   = memWb.regWrite;
    regWrite.idx  = memWb.rd;
    regWrite.data = memWb.value;
  end

endmodule

//--- executeStage.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module executeStage (
  input  cpuPkg::idEx_t     idEx,
  input  cpuPkg::exMem_t    exMemFwd,
  input  cpuPkg::regWrite_t wbFwd,
  output cpuPkg::exMem_t    result,
  output cpuPkg::redirect_t redirect
);

  cpuPkg::word_t opA;
  cpuPkg::word_t rs2Fwd;
  cpuPkg::word_t opB;
  cpuPkg::word_t aluOut;
  logic          equal;

  // Nearest producer first: EX/MEM, then writeback, then register file
  function automatic cpuPkg::word_t forwardOperand(
    input cpuPkg::regIdx_t   idx,
    input cpuPkg::word_t     regVal,
    input cpuPkg::exMem_t    memStage,
    input cpuPkg::regWrite_t wbStage
  );
    if (idx != '0 && memStage.regWrite && memStage.rd == idx) begin
      return memStage.aluResult;
    end
    if (idx != '0 && wbStage.en && wbStage.idx == idx) begin
      return wbStage.data;
    end
    return regVal;
  endfunction

  assign opA    = forwardOperand(idEx.rs1, idEx.rs1Val, exMemFwd, wbFwd);
  assign rs2Fwd = forwardOperand(idEx.rs2, idEx.rs2Val, exMemFwd, wbFwd);
  assign opB    = idEx.aluSrc ? idEx.imm : rs2Fwd;

  always_comb begin
    case (idEx.aluOp)
      cpuPkg::aluAdd:   aluOut = opA + opB;
      cpuPkg::aluSub:   aluOut = opA - opB;
      cpuPkg::aluAnd:   aluOut = opA & opB;
      cpuPkg::aluOr:    aluOut = opA | opB;
      cpuPkg::aluXor:   aluOut = opA ^ opB;
      cpuPkg::aluSlt:   aluOut = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
      cpuPkg::aluPassB: aluOut = opB;
      default:          aluOut = '0;
    endcase
  end

  always_comb begin
    result.aluResult = aluOut;
    result.storeData = rs2Fwd;
    result.rd        = idEx.rd;
    result.memRead   = idEx.memRead;
    result.memWrite  = idEx.memWrite;
    result.regWrite  = idEx.regWrite;
  end

  // BEQ and BNE compare the forwarded sources directly
  assign equal = (opA == rs2Fwd);

  always_comb begin
    redirect.taken  = idEx.branch && (idEx.branchNe ? !equal : equal);
    redirect.target = idEx.pc + idEx.imm;
  end

endmodule

//--- decodeStage.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module decodeStage (
  input  logic              clk,
  input  logic              rstN,
  input  cpuPkg::ifId_t     ifId,
  input  cpuPkg::regWrite_t regWrite,
  input  logic [4:0]        exLoadRd,
  input  logic              exIsLoad,
  output cpuPkg::idEx_t     decoded,
  output logic              loadUseStall
);

  cpuPkg::word_t   regs [`REG_COUNT];
  logic [31:0]     instr;
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  cpuPkg::regIdx_t rs1;
  cpuPkg::regIdx_t rs2;
  cpuPkg::word_t   rs1Val;
  cpuPkg::word_t   rs2Val;
  cpuPkg::word_t   imm;
  cpuPkg::aluOp_t  aluOp;
  logic            usesRs1;
  logic            usesRs2;
  logic            aluSrc;
  logic            memRead;
  logic            memWrite;
  logic            writesRd;
  logic            branch;
  logic            branchNe;

  assign instr  = ifId.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (regWrite.en && regWrite.idx != '0) begin
      regs[regWrite.idx] <= regWrite.data;
    end
  end

  // Unused source fields are zeroed so they never match a hazard
  assign rs1 = usesRs1 ? instr[19:15] : '0;
  assign rs2 = usesRs2 ? instr[24:20] : '0;

  // Write-first read, x0 hardwired
  assign rs1Val = (rs1 == '0) ? '0 :
                  (regWrite.en && regWrite.idx == rs1) ? regWrite.data : regs[rs1];
  assign rs2Val = (rs2 == '0) ? '0 :
                  (regWrite.en && regWrite.idx == rs2) ? regWrite.data : regs[rs2];

  always_comb begin
    usesRs1  = 1'b0;
    usesRs2  = 1'b0;
    aluSrc   = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    writesRd = 1'b0;
    branch   = 1'b0;
    branchNe = 1'b0;
    aluOp    = cpuPkg::aluAdd;
    imm      = '0;
    case (opcode)
      7'b0110011: begin
        usesRs1  = 1'b1;
        usesRs2  = 1'b1;
        writesRd = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: aluOp = cpuPkg::aluAdd;
          {7'h20, 3'b000}: aluOp = cpuPkg::aluSub;
          {7'h00, 3'b111}: aluOp = cpuPkg::aluAnd;
          {7'h00, 3'b110}: aluOp = cpuPkg::aluOr;
          {7'h00, 3'b100}: aluOp = cpuPkg::aluXor;
          {7'h00, 3'b010}: aluOp = cpuPkg::aluSlt;
          default: begin
            usesRs1  = 1'b0;
            usesRs2  = 1'b0;
            writesRd = 1'b0;
          end
        endcase
      end
      7'b0010011: begin
        if (funct3 == 3'b000) begin
          usesRs1  = 1'b1;
          aluSrc   = 1'b1;
          writesRd = 1'b1;
          imm      = {{20{instr[31]}}, instr[31:20]};
        end
      end
      7'b0110111: begin
        aluSrc   = 1'b1;
        writesRd = 1'b1;
        aluOp    = cpuPkg::aluPassB;
        imm      = {instr[31:12], 12'b0};
      end
      7'b0000011: begin
        if (funct3 == 3'b010) begin
          usesRs1  = 1'b1;
          aluSrc   = 1'b1;
          memRead  = 1'b1;
          writesRd = 1'b1;
          imm      = {{20{instr[31]}}, instr[31:20]};
        end
      end
      7'b0100011: begin
        if (funct3 == 3'b010) begin
          usesRs1  = 1'b1;
          usesRs2  = 1'b1;
          aluSrc   = 1'b1;
          memWrite = 1'b1;
          imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        end
      end
      7'b1100011: begin
        if (funct3 == 3'b000 || funct3 == 3'b001) begin
          usesRs1  = 1'b1;
          usesRs2  = 1'b1;
          branch   = 1'b1;
          branchNe = funct3[0];
          imm      = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                      instr[11:8], 1'b0};
        end
      end
      // Anything else falls through as a no-op
      default: ;
    endcase
  end

  always_comb begin
    decoded          = '0;
    decoded.pc       = ifId.pc;
    decoded.rs1Val   = rs1Val;
    decoded.rs2Val   = rs2Val;
    decoded.imm      = imm;
    decoded.rs1      = rs1;
    decoded.rs2      = rs2;
    decoded.rd       = writesRd ? instr[11:7] : '0;
    decoded.aluOp    = aluOp;
    decoded.aluSrc   = aluSrc;
    decoded.memRead  = memRead;
    decoded.memWrite = memWrite;
    decoded.regWrite = writesRd;
    decoded.branch   = branch;
    decoded.branchNe = branchNe;
  end

  assign loadUseStall = exIsLoad && exLoadRd != '0 && (exLoadRd == rs1 || exLoadRd == rs2);

endmodule

//--- fetchStage.sv
`timescale 1ns/100ps
`include "cpu_defines.svh"

module fetchStage (
  input  logic              clk,
  input  logic              rstN,
  input  logic              stall,
  input  cpuPkg::redirect_t redirect,
  output cpuPkg::ifId_t     fetched
);

  localparam int RomAw = $clog2(`IMEM_DEPTH);

  cpuPkg::word_t pc;
  logic [31:0]   rom [`IMEM_DEPTH];

  initial begin
    $readmemh("program.hex", rom);
  end

  // Branch target wins even while the pipeline is frozen
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc <= `RESET_PC;
    end else if (redirect.taken) begin
      pc <= redirect.target;
    end else if (!stall) begin
      pc <= pc + `XLEN'(4);
    end
  end

  // Word-addressed ROM, low two PC bits ignored
  always_comb begin
    fetched.pc    = pc;
    fetched.instr = rom[pc[RomAw+1:2]];
  end

endmodule

//--- stageRegister.sv
`timescale 1ns/100ps

module stageRegister #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rstN,
  input  logic     stall,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  // A frozen pipeline keeps its contents, so hold beats flush
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      q <= '0;
    end else if (stall) begin
      q <= q;
    end else if (flush) begin
      q <= '0;
    end else begin
      q <= d;
    end
  end

endmodule

//--- cpuPkg.sv
`include "cpu_defines.svh"

package cpuPkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [$clog2(`REG_COUNT)-1:0] regIdx_t;

  // passB feeds the immediate straight through for LUI
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt,
    aluPassB
  } aluOp_t;

  typedef struct packed {
    word_t       pc;
    logic [31:0] instr;
  } ifId_t;

  typedef struct packed {
    word_t   pc;
    word_t   rs1Val;
    word_t   rs2Val;
    word_t   imm;
    regIdx_t rs1;
    regIdx_t rs2;
    regIdx_t rd;
    aluOp_t  aluOp;
    logic    aluSrc;
    logic    memRead;
    logic    memWrite;
    logic    regWrite;
    logic    branch;
    logic    branchNe;
  } idEx_t;

  typedef struct packed {
    word_t   aluResult;
    word_t   storeData;
    regIdx_t rd;
    logic    memRead;
    logic    memWrite;
    logic    regWrite;
  } exMem_t;

  typedef struct packed {
    word_t   value;
    regIdx_t rd;
    logic    regWrite;
  } memWb_t;

  typedef struct packed {
    logic    en;
    regIdx_t idx;
    word_t   data;
  } regWrite_t;

  typedef struct packed {
    logic  taken;
    word_t target;
  } redirect_t;

  // Master side of a Wishbone classic port
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [`XLEN/8-1:0]   sel;
    word_t                adr;
    word_t                dat;
  } wbReq_t;

endpackage

//--- cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data path width
`define XLEN 32

// Architectural registers, x0 included
`define REG_COUNT 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Instruction ROM size in words
`define IMEM_DEPTH 64

`endif
